// ==== hdl/div_config.svh ====
`ifndef DIV_CONFIG_SVH
`define DIV_CONFIG_SVH

// operand and result width of the Q8.8 format.
`define DIV_WIDTH 16

// number of fraction bits.
`define DIV_FRAC_BITS 8

// one quotient digit is produced per iteration.
`define DIV_STEPS (`DIV_WIDTH + `DIV_FRAC_BITS - 1)

`define DIV_QUOT_WIDTH `DIV_STEPS

`endif

// ==== hdl/fixp_pkg.sv ====
`include "div_config.svh"

package fixp_pkg;

    // ------------------------------------------------------------------
    // number formats
    // ------------------------------------------------------------------

    // signed value with DIV_FRAC_BITS fraction bits.
    typedef logic signed [`DIV_WIDTH-1:0] q_t;

    // unsigned magnitude, wide enough for the most negative input.
    typedef logic [`DIV_WIDTH-1:0] mag_t;

    // full quotient magnitude before range checking.
    typedef logic [`DIV_QUOT_WIDTH-1:0] quot_mag_t;

endpackage

// ==== hdl/div_pkg.sv ====
package div_pkg;

    import fixp_pkg::*;

    // ------------------------------------------------------------------
    // operand preparation to iterative core
    // ------------------------------------------------------------------

    typedef struct packed {
        logic neg;                 // sign of the result.
        mag_t dividend_mag;
        mag_t divisor_mag;
    } div_op_t;

    // ------------------------------------------------------------------
    // iterative core to result formatting
    // ------------------------------------------------------------------

    typedef struct packed {
        logic      neg;            // carried along from the operands.
        quot_mag_t quot_mag;       // truncated quotient magnitude.
    } div_raw_t;

    // ------------------------------------------------------------------
    // result formatting to the outside
    // ------------------------------------------------------------------

    typedef struct packed {
        q_t   quotient;
        logic overflow;            // quotient undefined when set.
    } div_resp_t;

endpackage

// ==== hdl/add_sub.sv ====
`timescale 1ns/100ps

module add_sub #(
    parameter int WIDTH = 24
) (
    input  logic [WIDTH-1:0] a,
    input  logic [WIDTH-1:0] b,
    input  logic             subtract,
    output logic [WIDTH-1:0] sum,
    output logic             carry,
    output logic             overflow,
    output logic             negative
);

    logic [WIDTH-1:0] b_eff;
    logic [WIDTH:0]   full;

    // subtraction is a plus the one's complement of b plus one.
    assign b_eff = subtract ? ~b : b;

    assign full = {1'b0, a} + {1'b0, b_eff} + {{WIDTH{1'b0}}, subtract};

    assign sum   = full[WIDTH-1:0];
    assign carry = full[WIDTH];       // borrow is the inverse when subtracting.

    // operands of equal sign that give a result of the other sign.
    assign overflow = (a[WIDTH-1] == b_eff[WIDTH-1]) && (sum[WIDTH-1] != a[WIDTH-1]);

    assign negative = sum[WIDTH-1];

endmodule

// ==== hdl/div_operand_prep.sv ====
`timescale 1ns/100ps
`include "div_config.svh"

module div_operand_prep
    import fixp_pkg::*;
    import div_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    start,
    input  q_t      dividend,
    input  q_t      divisor,
    input  logic    busy,
    output div_op_t op,
    output logic    op_valid
);

    localparam int MSB = `DIV_WIDTH - 1;

    logic start_q;
    logic launch;
    mag_t dividend_mag;
    mag_t divisor_mag;

    // ------------------------------------------------------------------
    // start edge
    // ------------------------------------------------------------------

    // an edge is dropped while the core is busy or about to load.
    assign launch = start && !start_q && !busy && !op_valid;

    always_ff @(posedge clk) begin
        if (rst) begin
            start_q  <= 1'b1;              // a level held through reset is not an edge.
            op_valid <= 1'b0;
        end else begin
            start_q  <= start;
            op_valid <= launch;
        end
    end

    // ------------------------------------------------------------------
    // signs and magnitudes
    // ------------------------------------------------------------------

    // the most negative value negates to itself, read unsigned as 32768.
    assign dividend_mag = dividend[MSB] ? mag_t'(-dividend) : mag_t'(dividend);
    assign divisor_mag  = divisor[MSB] ? mag_t'(-divisor) : mag_t'(divisor);

    always_ff @(posedge clk) begin
        if (launch) begin
            op.neg          <= dividend[MSB] ^ divisor[MSB];
            op.dividend_mag <= dividend_mag;
            op.divisor_mag  <= divisor_mag;
        end
    end

    a_single_op_valid: assert property (
        @(posedge clk) disable iff (rst) op_valid |=> !op_valid
    ) else $error("op_valid held for more than one cycle.");

endmodule

// ==== hdl/div_core.sv ====
`timescale 1ns/100ps
`include "div_config.svh"

module div_core
    import fixp_pkg::*;
    import div_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  div_op_t  op,
    input  logic     op_valid,
    output div_raw_t raw,
    output logic     raw_valid,
    output logic     busy
);

    localparam int QW    = `DIV_QUOT_WIDTH;
    localparam int AW    = QW + 1;
    localparam int SW    = 2 * QW;
    localparam int CNT_W = $clog2(`DIV_STEPS);

    logic [SW-1:0]    sr;          // partial remainder above, dividend bits and digits below.
    logic [CNT_W-1:0] step_cnt;
    logic             sub_op;      // next step subtracts when the remainder is not negative.
    logic             neg_q;
    mag_t             divisor_q;
    logic [AW-1:0]    add_a;
    logic [AW-1:0]    add_b;
    logic [AW-1:0]    add_sum;
    logic             add_neg;
    logic             last_step;
    quot_mag_t        quot;

    // ------------------------------------------------------------------
    // remainder update
    // ------------------------------------------------------------------

    // twice the remainder plus the next dividend bit.
    assign add_a = {sr[SW-1:QW], sr[QW-1]};
    assign add_b = AW'(divisor_q);

    add_sub #(
        .WIDTH (AW)
    ) rem_add_i (
        .a        (add_a),
        .b        (add_b),
        .subtract (sub_op),
        .sum      (add_sum),
        .carry    (),
        .overflow (),
        .negative (add_neg)
    );

    // ------------------------------------------------------------------
    // step control
    // ------------------------------------------------------------------

    assign last_step = (step_cnt == CNT_W'(`DIV_STEPS - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            busy      <= 1'b0;
            raw_valid <= 1'b0;
            step_cnt  <= '0;
        end else begin
            raw_valid <= 1'b0;
            if (op_valid) begin
                busy     <= 1'b1;
                step_cnt <= '0;
            end else if (busy) begin
                step_cnt <= step_cnt + 1'b1;
                if (last_step) begin
                    busy      <= 1'b0;
                    raw_valid <= 1'b1;
                end
            end
        end
    end

    // ------------------------------------------------------------------
    // shift register
    // ------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (op_valid) begin
            sr        <= SW'(op.dividend_mag) << `DIV_FRAC_BITS;
            divisor_q <= op.divisor_mag;
            neg_q     <= op.neg;
            sub_op    <= 1'b1;             // the first remainder is never negative.
        end else if (busy) begin
            sr     <= {add_sum[QW-1:0], sr[QW-2:0], sub_op};
            sub_op <= ~add_neg;
        end
    end

    // each recorded digit is the sign of the remainder one step earlier.
    // dropping the oldest and appending the pending op bit gives the quotient.
    assign quot = {sr[QW-2:0], sub_op};

    assign raw = '{neg: neg_q, quot_mag: quot};

    a_no_op_while_busy: assert property (
        @(posedge clk) disable iff (rst) op_valid |-> !busy
    ) else $error("operands arrived while a division was running.");

    a_no_raw_while_busy: assert property (
        @(posedge clk) disable iff (rst) raw_valid |-> !busy
    ) else $error("raw_valid raised while still busy.");

endmodule

// ==== hdl/div_result_format.sv ====
`timescale 1ns/100ps
`include "div_config.svh"

module div_result_format
    import fixp_pkg::*;
    import div_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  div_raw_t  raw,
    input  logic      raw_valid,
    output div_resp_t resp,
    output logic      finish
);

    localparam int W  = `DIV_WIDTH;
    localparam int QW = `DIV_QUOT_WIDTH;

    logic ovf;
    q_t   q_abs;
    q_t   q_signed;

    // ------------------------------------------------------------------
    // range check and sign
    // ------------------------------------------------------------------

    // any magnitude of 128.0 or more does not fit the signed format.
    assign ovf = |raw.quot_mag[QW-1:W-1];

    assign q_abs    = q_t'(raw.quot_mag[W-1:0]);
    assign q_signed = raw.neg ? -q_abs : q_abs;

    // ------------------------------------------------------------------
    // output register
    // ------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (rst) begin
            resp   <= '0;
            finish <= 1'b0;
        end else begin
            finish <= raw_valid;
            if (raw_valid) begin
                resp.quotient <= q_signed;
                resp.overflow <= ovf;      // kept until the next finish.
            end
        end
    end

    a_finish_pulse: assert property (
        @(posedge clk) disable iff (rst) finish |=> !finish
    ) else $error("finish lasted more than one cycle.");

endmodule

// ==== hdl/fixp_divider.sv ====
`timescale 1ns/100ps

module fixp_divider
    import fixp_pkg::*;
    import div_pkg::*;
(
    input  logic clk,
    input  logic rst,
    input  logic start,
    input  q_t   dividend,
    input  q_t   divisor,
    output q_t   result,
    output logic overflow,
    output logic finish
);

    div_op_t   op;
    logic      op_valid;
    logic      busy;
    div_raw_t  raw;
    logic      raw_valid;
    div_resp_t resp;

    // ------------------------------------------------------------------
    // pipeline stages
    // ------------------------------------------------------------------

    div_operand_prep prep_i (
        .clk      (clk),
        .rst      (rst),
        .start    (start),
        .dividend (dividend),
        .divisor  (divisor),
        .busy     (busy),
        .op       (op),
        .op_valid (op_valid)
    );

    div_core core_i (
        .clk       (clk),
        .rst       (rst),
        .op        (op),
        .op_valid  (op_valid),
        .raw       (raw),
        .raw_valid (raw_valid),
        .busy      (busy)
    );

    div_result_format format_i (
        .clk       (clk),
        .rst       (rst),
        .raw       (raw),
        .raw_valid (raw_valid),
        .resp      (resp),
        .finish    (finish)
    );

    // ------------------------------------------------------------------
    // outputs
    // ------------------------------------------------------------------

    assign result   = resp.quotient;
    assign overflow = resp.overflow;

endmodule

// ==== bench/fixp_divider_tb.sv ====
`timescale 1ns/100ps

module fixp_divider_tb
    import fixp_pkg::*;
    import div_pkg::*;
;

    localparam int LATENCY        = 25;
    localparam int FINISH_TIMEOUT = 40;
    localparam int RANDOM_PAIRS   = 300;

    logic clk;
    logic rst;
    logic start;
    q_t   dividend;
    q_t   divisor;
    q_t   result;
    logic overflow;
    logic finish;

    div_resp_t exp_resp;
    q_t        cur_dividend;
    q_t        cur_divisor;
    logic      expecting;
    int        finish_count;
    integer    seed;

    fixp_divider dut_i (
        .clk      (clk),
        .rst      (rst),
        .start    (start),
        .dividend (dividend),
        .divisor  (divisor),
        .result   (result),
        .overflow (overflow),
        .finish   (finish)
    );

    always #5 clk = ~clk;

    // ------------------------------------------------------------------
    // expected values
    // ------------------------------------------------------------------

    function automatic div_resp_t reference_divide(input q_t a, input q_t b);
        longint    abs_a;
        longint    abs_b;
        longint    mag;
        div_resp_t r;
        abs_a = a;
        abs_b = b;
        if (abs_a < 0)
            abs_a = -abs_a;
        if (abs_b < 0)
            abs_b = -abs_b;
        mag = 0;
        if (abs_b != 0)
            mag = (abs_a * 256) / abs_b;          // truncated toward zero.
        r.overflow = (abs_b == 0) || (mag >= 32768);
        r.quotient = (a[15] ^ b[15]) ? q_t'(-mag) : q_t'(mag);
        return r;
    endfunction

    // ------------------------------------------------------------------
    // failure reporting
    // ------------------------------------------------------------------

    task automatic stop_with_error(input string what);
        $display("%s", what);
        $display("Finished with errors");
        $fatal(1, "simulation stopped at the first error.");
    endtask

    task automatic report_mismatch(input string what);
        stop_with_error($sformatf("FAIL at %0t ns: %s (dividend %h, divisor %h)",
                                  $time, what, cur_dividend, cur_divisor));
    endtask

    // ------------------------------------------------------------------
    // stimulus
    // ------------------------------------------------------------------

    // raises start on a falling edge and returns after the edge that samples it.
    task automatic apply_operands(input q_t a, input q_t b);
        @(negedge clk);
        exp_resp     = reference_divide(a, b);
        cur_dividend = a;
        cur_divisor  = b;
        dividend     = a;
        divisor      = b;
        start        = 1'b1;
        expecting    = 1'b1;
        @(posedge clk);
    endtask

    task automatic release_start();
        @(negedge clk);
        start = 1'b0;
    endtask

    // counts rising edges after the start edge until finish is seen.
    task automatic wait_finish(output int cycles);
        int   n;
        logic done;
        n    = 0;
        done = 1'b0;
        while (!done && n < FINISH_TIMEOUT) begin
            @(posedge clk);
            n++;
            @(negedge clk);
            done = finish;
        end
        if (!done)
            stop_with_error("Timeout: finish never came within 40 cycles of the start edge.");
        cycles = n;
    endtask

    task automatic check_latency(input int cycles);
        assert (cycles == LATENCY)
        else report_mismatch($sformatf("latency %0d cycles, expected %0d", cycles, LATENCY));
    endtask

    task automatic run_division(input q_t a, input q_t b);
        int cycles;
        apply_operands(a, b);
        release_start();
        wait_finish(cycles);
        check_latency(cycles);
    endtask

    // no finish may appear in this window.
    task automatic check_quiet(input int count_before);
        repeat (FINISH_TIMEOUT) @(negedge clk);
        @(posedge clk);
        assert (finish_count == count_before + 1)
        else report_mismatch($sformatf("%0d finish pulses, expected one",
                                       finish_count - count_before));
    endtask

    // ------------------------------------------------------------------
    // checker
    // ------------------------------------------------------------------

    always @(negedge clk) begin
        if (!rst && finish) begin
            finish_count++;
            assert (expecting)
            else stop_with_error("A finish pulse came with no division in progress.");
            expecting = 1'b0;
            assert (overflow == exp_resp.overflow)
            else report_mismatch($sformatf("overflow %b, expected %b",
                                           overflow, exp_resp.overflow));
            if (!exp_resp.overflow) begin
                assert (result == exp_resp.quotient)
                else report_mismatch($sformatf("result %h, expected %h",
                                               result, exp_resp.quotient));
            end
        end
    end

    // ------------------------------------------------------------------
    // test sequence
    // ------------------------------------------------------------------

    initial begin
        int cycles;
        int count_before;
        clk          = 1'b0;
        rst          = 1'b1;
        start        = 1'b1;             // a level held through reset must not launch.
        dividend     = '0;
        divisor      = '0;
        expecting    = 1'b0;
        finish_count = 0;
        exp_resp     = '0;
        cur_dividend = '0;
        cur_divisor  = '0;
        seed         = 32'h417a_3c5c;
        repeat (5) @(negedge clk);
        rst = 1'b0;
        repeat (FINISH_TIMEOUT) @(negedge clk);
        start = 1'b0;
        repeat (2) @(negedge clk);

        // directed positive quotients.
        run_division(16'h0600, 16'h0200);
        run_division(16'h0100, 16'h0300);
        run_division(16'h0080, 16'h0400);

        // all sign combinations.
        run_division(16'hFA00, 16'h0200);
        run_division(16'h0600, 16'hFE00);
        run_division(16'hFA00, 16'hFE00);
        run_division(16'h8000, 16'h0200);
        run_division(16'h0000, 16'hFD00);
        run_division(16'hFF00, 16'h0300);

        // range limits.
        run_division(16'h6400, 16'h0040);
        run_division(16'h8000, 16'hFFFF);
        run_division(16'h7FFF, 16'h0100);
        run_division(16'h8001, 16'h0100);
        run_division(16'h3F80, 16'h0080);

        // zero divisor.
        run_division(16'h0600, 16'h0000);
        run_division(16'h0000, 16'h0000);
        run_division(16'h8000, 16'h0000);

        for (int i = 0; i < RANDOM_PAIRS; i++)
            run_division(q_t'($random(seed)), q_t'($random(seed)));

        // start held high makes a single edge.
        apply_operands(16'h0300, 16'h0200);
        count_before = finish_count;
        wait_finish(cycles);
        check_latency(cycles);
        repeat (60 - 1 - cycles) @(negedge clk);
        start = 1'b0;
        check_quiet(count_before);

        // an edge while the core is busy is dropped.
        apply_operands(16'h0500, 16'h0400);
        count_before = finish_count;
        release_start();
        fork
            wait_finish(cycles);
            begin
                repeat (9) @(negedge clk);
                dividend = 16'h7000;
                divisor  = 16'h0100;
                start    = 1'b1;
                @(negedge clk);
                start = 1'b0;
            end
        join
        check_latency(cycles);
        check_quiet(count_before);

        $display("Finished with no errors");
        $finish;
    end

endmodule

// ==== sim.f ====
+incdir+hdl
hdl/fixp_pkg.sv
hdl/div_pkg.sv
hdl/add_sub.sv
hdl/div_operand_prep.sv
hdl/div_core.sv
hdl/div_result_format.sv
hdl/fixp_divider.sv
bench/fixp_divider_tb.sv
